// File: rtl/cpu_macros.svh
/*
 * Width and count macros for the integer execute pipeline:
 * register value, register number, immediate and operation code
 * widths, register file depth and number of source operands.
 */

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath widths
`define CPU_REG_WIDTH    32  // Register value
`define CPU_REGNO_WIDTH  5   // Register number
`define CPU_IMM_WIDTH    16  // Immediate field
`define CPU_OP_WIDTH     3   // ALU operation code

// Counts
`define CPU_NUM_REGS     32  // Register file depth
`define CPU_NUM_SRC      2   // Source operands, 0 is rs and 1 is rt

`endif

// File: rtl/cpu_types_pkg.sv
/*
 * Data typedefs of the pipeline: register values,
 * register numbers and immediates.
 */

`include "cpu_macros.svh"

package cpu_types_pkg;

  // Register value
  typedef logic [`CPU_REG_WIDTH-1:0] reg_t;

  // Register number, 0 is the hardwired zero register
  typedef logic [`CPU_REGNO_WIDTH-1:0] regno_t;

  // Raw immediate, before any extension
  typedef logic [`CPU_IMM_WIDTH-1:0] imm_t;

endpackage

// File: rtl/cpu_ops_pkg.sv
/*
 * ALU operation typedef and the named operation codes
 * executed by the pipeline.
 */

`include "cpu_macros.svh"

package cpu_ops_pkg;

  typedef logic [`CPU_OP_WIDTH-1:0] alu_op_t;

  // Register-register operations
  localparam alu_op_t OP_ADD  = 'd0;  // rs + rt
  localparam alu_op_t OP_SUB  = 'd1;  // rs - rt
  localparam alu_op_t OP_AND  = 'd2;  // Bitwise and
  localparam alu_op_t OP_OR   = 'd3;  // Bitwise or
  localparam alu_op_t OP_XOR  = 'd4;  // Bitwise xor
  localparam alu_op_t OP_SLT  = 'd5;  // Signed rs < rt, 0 or 1

  // Immediate operations
  localparam alu_op_t OP_ADDI = 'd6;  // rs + sign-extended imm
  localparam alu_op_t OP_LUI  = 'd7;  // imm in the upper half

endpackage

// File: rtl/decode_stage.sv
/*
 * Decode stage: 32-entry register file with register 0 tied to zero
 * and write-through from the writeback port, plus the p2 pipeline
 * register that holds the issued instruction and its source operands.
 */

`timescale 1ns/10ps
`include "cpu_macros.svh"

module decode_stage
  import cpu_types_pkg::*, cpu_ops_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          issue,     // Instruction strobe
  input  alu_op_t                       op,
  input  regno_t                        rs,
  input  regno_t                        rt,
  input  regno_t                        rd,
  input  imm_t                          imm,
  input  logic                          wr_en,     // Writeback port
  input  regno_t                        wr_no,
  input  reg_t                          wr_data,
  output logic                          valid_p2,
  output alu_op_t                       op_p2,
  output regno_t                        rd_p2,
  output imm_t                          imm_p2,
  output regno_t [`CPU_NUM_SRC-1:0]     src_no,    // Source numbers at p2
  output reg_t   [`CPU_NUM_SRC-1:0]     src_data   // Register file data at p2
);

  reg_t                       regs [`CPU_NUM_REGS];  // Entry 0 never written
  regno_t [`CPU_NUM_SRC-1:0]  src_sel;               // Sources being issued
  reg_t   [`CPU_NUM_SRC-1:0]  src_rd;                // Combinational read

  assign src_sel[0] = rs;
  assign src_sel[1] = rt;

  // Read ports, a same-cycle write is passed through
  always_comb
  begin
    for (int i = 0; i < `CPU_NUM_SRC; i++)
    begin
      if (src_sel[i] == '0)
        src_rd[i] = '0;                      // Zero register
      else if (wr_en && wr_no == src_sel[i])
        src_rd[i] = wr_data;                 // Write-through
      else
        src_rd[i] = regs[src_sel[i]];
    end
  end

  // Write port
  always_ff @(posedge clk)
  begin
    if (wr_en && wr_no != '0)
      regs[wr_no] <= wr_data;
  end

  // p2 control, empty issue slots become bubbles
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_p2 <= 1'b0;
      rd_p2    <= '0;
    end
    else
    begin
      valid_p2 <= issue;
      rd_p2    <= issue ? rd : regno_t'(0);  // Bubble targets r0
    end
  end

  // p2 payload
  always_ff @(posedge clk)
  begin
    op_p2    <= op;
    imm_p2   <= imm;
    src_no   <= src_sel;
    src_data <= src_rd;
  end

  // A write to r0 on the writeback port must leave entry 0 untouched
  a_r0_stays_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en && wr_no == '0 |=> regs[0] === $past(regs[0]))
    else $error("register 0 changed by a write to it");

endmodule

// File: rtl/operand_fwd.sv
/*
 * Forwarding multiplexer for one source operand. Selects the newest
 * value: memory stage, then writeback stage, then register file.
 */

`timescale 1ns/10ps

module operand_fwd
  import cpu_types_pkg::*;
(
  input  regno_t src_no,      // Source register at p2
  input  reg_t   src_data,    // Register file value
  input  regno_t rd_p3,       // Memory stage destination
  input  reg_t   rd_data_p3,
  input  regno_t rd_p4,       // Writeback stage destination
  input  reg_t   rd_data_p4,
  output reg_t   fwd_data     // Forwarded operand
);

  always_comb
  begin
    if (src_no != '0 && src_no == rd_p3)
      fwd_data = rd_data_p3;             // Newest producer
    else if (src_no != '0 && src_no == rd_p4)
      fwd_data = rd_data_p4;
    else
      fwd_data = src_data;               // No match or r0
  end

  // Memory stage must win even when writeback holds the same register
  always_comb
  begin
    if (src_no != '0 && src_no == rd_p3)
      a_mem_fwd: assert final (fwd_data == rd_data_p3)
        else $error("operand r%0d not taken from memory stage", src_no);
  end

endmodule

// File: rtl/exec_pipe.sv
/*
 * Execute pipe: eight-operation ALU on the forwarded operands,
 * memory-stage and writeback-stage registers, stage destination
 * buses for forwarding, register file write port and writeback report.
 */

`timescale 1ns/10ps
`include "cpu_macros.svh"

module exec_pipe
  import cpu_types_pkg::*, cpu_ops_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      valid_p2,
  input  alu_op_t                   op_p2,
  input  regno_t                    rd_p2,
  input  imm_t                      imm_p2,
  input  reg_t [`CPU_NUM_SRC-1:0]   fwd_data,    // Forwarded rs and rt
  output regno_t                    rd_p3,       // Memory stage
  output reg_t                      rd_data_p3,
  output regno_t                    rd_p4,       // Writeback stage
  output reg_t                      rd_data_p4,
  output logic                      wr_en,       // Register file write
  output regno_t                    wr_no,
  output reg_t                      wr_data,
  output logic                      wb_valid,    // Writeback report
  output regno_t                    wb_rd,
  output reg_t                      wb_data
);

  reg_t opa;          // rs operand
  reg_t opb;          // rt operand
  reg_t imm_sx;       // Sign-extended immediate
  reg_t imm_hi;       // Immediate in upper half
  reg_t alu_res;
  logic valid_p3;
  logic valid_p4;

  assign opa    = fwd_data[0];
  assign opb    = fwd_data[1];
  assign imm_sx = {{(`CPU_REG_WIDTH-`CPU_IMM_WIDTH){imm_p2[`CPU_IMM_WIDTH-1]}}, imm_p2};
  assign imm_hi = {imm_p2, {(`CPU_REG_WIDTH-`CPU_IMM_WIDTH){1'b0}}};

  // ALU
  always_comb
  begin
    case (op_p2)
      OP_ADD:  alu_res = opa + opb;
      OP_SUB:  alu_res = opa - opb;
      OP_AND:  alu_res = opa & opb;
      OP_OR:   alu_res = opa | opb;
      OP_XOR:  alu_res = opa ^ opb;
      OP_SLT:  alu_res = {{(`CPU_REG_WIDTH-1){1'b0}}, $signed(opa) < $signed(opb)};
      OP_ADDI: alu_res = opa + imm_sx;
      OP_LUI:  alu_res = imm_hi;
      default: alu_res = '0;
    endcase
  end

  // Stage control, bubbles carry destination 0
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_p3 <= 1'b0;
      rd_p3    <= '0;
      valid_p4 <= 1'b0;
      rd_p4    <= '0;
    end
    else
    begin
      valid_p3 <= valid_p2;
      rd_p3    <= valid_p2 ? rd_p2 : regno_t'(0);
      valid_p4 <= valid_p3;
      rd_p4    <= rd_p3;
    end
  end

  // Result payload
  always_ff @(posedge clk)
  begin
    rd_data_p3 <= alu_res;
    rd_data_p4 <= rd_data_p3;   // Memory stage only passes through
  end

  // One writeback register, two port groups
  assign wr_en    = valid_p4;
  assign wr_no    = rd_p4;
  assign wr_data  = rd_data_p4;
  assign wb_valid = valid_p4;
  assign wb_rd    = rd_p4;
  assign wb_data  = rd_data_p4;

  // Destination must be resolved by the time a result retires
  a_wb_rd_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_valid |-> !$isunknown(wb_rd))
    else $error("writeback with unknown destination");

endmodule

// File: rtl/int_pipe_top.sv
/*
 * Top level of the integer execute pipeline: decode stage,
 * one forwarding multiplexer per source operand, execute pipe.
 */

`timescale 1ns/10ps
`include "cpu_macros.svh"

module int_pipe_top
  import cpu_types_pkg::*, cpu_ops_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    issue,
  input  alu_op_t op,
  input  regno_t  rs,
  input  regno_t  rt,
  input  regno_t  rd,
  input  imm_t    imm,
  output logic    wb_valid,
  output regno_t  wb_rd,
  output reg_t    wb_data
);

  logic                       valid_p2;
  alu_op_t                    op_p2;
  regno_t                     rd_p2;
  imm_t                       imm_p2;
  regno_t [`CPU_NUM_SRC-1:0]  src_no;
  reg_t   [`CPU_NUM_SRC-1:0]  src_data;
  reg_t   [`CPU_NUM_SRC-1:0]  fwd_data;
  regno_t                     rd_p3;
  reg_t                       rd_data_p3;
  regno_t                     rd_p4;
  reg_t                       rd_data_p4;
  logic                       wr_en;
  regno_t                     wr_no;
  reg_t                       wr_data;

  decode_stage u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .op       (op),
    .rs       (rs),
    .rt       (rt),
    .rd       (rd),
    .imm      (imm),
    .wr_en    (wr_en),
    .wr_no    (wr_no),
    .wr_data  (wr_data),
    .valid_p2 (valid_p2),
    .op_p2    (op_p2),
    .rd_p2    (rd_p2),
    .imm_p2   (imm_p2),
    .src_no   (src_no),
    .src_data (src_data)
  );

  // One forwarder per source operand
  for (genvar g = 0; g < `CPU_NUM_SRC; g++)
  begin : g_fwd
    operand_fwd u_fwd (
      .src_no     (src_no[g]),
      .src_data   (src_data[g]),
      .rd_p3      (rd_p3),
      .rd_data_p3 (rd_data_p3),
      .rd_p4      (rd_p4),
      .rd_data_p4 (rd_data_p4),
      .fwd_data   (fwd_data[g])
    );
  end

  exec_pipe u_exec (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_p2   (valid_p2),
    .op_p2      (op_p2),
    .rd_p2      (rd_p2),
    .imm_p2     (imm_p2),
    .fwd_data   (fwd_data),
    .rd_p3      (rd_p3),
    .rd_data_p3 (rd_data_p3),
    .rd_p4      (rd_p4),
    .rd_data_p4 (rd_data_p4),
    .wr_en      (wr_en),
    .wr_no      (wr_no),
    .wr_data    (wr_data),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

// File: tb/tb_clkgen.sv
/*
 * Testbench clock and reset generator:
 * 4 ns clock, active-low synchronous reset held for 3 cycles.
 */

`timescale 1ns/10ps

module tb_clkgen
(
  output logic clk,
  output logic rst_n
);

  localparam real HALF_PERIOD  = 2.0;  // 4 ns period
  localparam int  RESET_CYCLES = 3;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;                      // Released on a falling edge
  end

endmodule

// File: tb/tb_int_pipe.sv
/*
 * Table-driven testbench of the integer execute pipeline:
 * stimulus table with hand-worked writeback values, compare task,
 * cycle-count timeout and pass/fail reporting.
 */

`timescale 1ns/10ps
`include "cpu_macros.svh"

module tb_int_pipe
  import cpu_types_pkg::*, cpu_ops_pkg::*;
();

  localparam int LATENCY = 3;          // Issue edge to writeback check
  localparam int MARGIN  = 10;         // Extra cycles before timeout

  logic    clk;
  logic    rst_n;
  logic    issue;
  alu_op_t op;
  regno_t  rs;
  regno_t  rt;
  regno_t  rd;
  imm_t    imm;
  logic    wb_valid;
  regno_t  wb_rd;
  reg_t    wb_data;

  // Stimulus table, one entry per issue cycle
  string   name_q[$];
  logic    issue_q[$];
  alu_op_t op_q[$];
  regno_t  rs_q[$];
  regno_t  rt_q[$];
  regno_t  rd_q[$];
  imm_t    imm_q[$];
  regno_t  exp_rd_q[$];
  reg_t    exp_data_q[$];
  int      cycle_cnt;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  int_pipe_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .op       (op),
    .rs       (rs),
    .rt       (rt),
    .rd       (rd),
    .imm      (imm),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  task automatic add_row(input string name, input logic iss, input alu_op_t o,
                         input regno_t s, input regno_t t, input regno_t d,
                         input imm_t i, input regno_t erd, input reg_t edata);
    name_q.push_back(name);
    issue_q.push_back(iss);
    op_q.push_back(o);
    rs_q.push_back(s);
    rt_q.push_back(t);
    rd_q.push_back(d);
    imm_q.push_back(i);
    exp_rd_q.push_back(erd);
    exp_data_q.push_back(edata);
  endtask

  // Columns: name, issue, op, rs, rt, rd, imm, expected wb_rd, expected wb_data
  task automatic build_table();
    add_row("lui_r1",      1, OP_LUI,  0,  0,  1,  'h1234, 1,  'h12340000);
    add_row("addi_r2",     1, OP_ADDI, 0,  0,  2,  'h0005, 2,  'h00000005);
    add_row("addi_r3_neg", 1, OP_ADDI, 0,  0,  3,  'hfffd, 3,  'hfffffffd);
    add_row("addi_r4",     1, OP_ADDI, 0,  0,  4,  'h00f0, 4,  'h000000f0);
    add_row("bubble_r2",   0, OP_ADDI, 0,  0,  2,  'h0abc, 0,  'h0);  // Must not clobber r2
    add_row("add",         1, OP_ADD,  2,  4,  5,  'h0000, 5,  'h000000f5);
    add_row("sub",         1, OP_SUB,  2,  3,  6,  'h0000, 6,  'h00000008);
    add_row("and",         1, OP_AND,  3,  4,  7,  'h0000, 7,  'h000000f0);
    add_row("or",          1, OP_OR,   1,  2,  8,  'h0000, 8,  'h12340005);
    add_row("xor",         1, OP_XOR,  3,  4,  9,  'h0000, 9,  'hffffff0d);
    add_row("slt_neg",     1, OP_SLT,  3,  2,  10, 'h0000, 10, 'h00000001);  // -3 < 5
    add_row("slt_pos",     1, OP_SLT,  2,  3,  11, 'h0000, 11, 'h00000000);
    add_row("mem_prod",    1, OP_ADDI, 0,  0,  12, 'h0100, 12, 'h00000100);
    add_row("mem_fwd_rs",  1, OP_ADD,  12, 2,  13, 'h0000, 13, 'h00000105);
    add_row("mem_fwd_rt",  1, OP_SUB,  4,  13, 14, 'h0000, 14, 'hffffffeb);
    add_row("wb_prod",     1, OP_ADDI, 0,  0,  15, 'h0007, 15, 'h00000007);
    add_row("wb_fill",     1, OP_ADDI, 0,  0,  16, 'h0011, 16, 'h00000011);
    add_row("wb_fwd",      1, OP_ADD,  15, 16, 17, 'h0000, 17, 'h00000018);
    add_row("same_old",    1, OP_ADDI, 0,  0,  18, 'h0020, 18, 'h00000020);
    add_row("same_new",    1, OP_ADDI, 0,  0,  18, 'h0030, 18, 'h00000030);
    add_row("same_use",    1, OP_ADD,  18, 18, 19, 'h0000, 19, 'h00000060);  // Newer wins
    add_row("wt_prod",     1, OP_ADDI, 0,  0,  20, 'h0044, 20, 'h00000044);
    add_row("wt_fill1",    1, OP_ADDI, 0,  0,  21, 'h0001, 21, 'h00000001);
    add_row("wt_fill2",    1, OP_ADDI, 0,  0,  22, 'h0002, 22, 'h00000002);
    add_row("wt_use",      1, OP_ADD,  20, 20, 23, 'h0000, 23, 'h00000088);
    add_row("r0_write",    1, OP_ADDI, 0,  0,  0,  'h0055, 0,  'h00000055);
    add_row("r0_read_mem", 1, OP_ADD,  0,  0,  24, 'h0000, 24, 'h00000000);
    add_row("r0_read_wb",  1, OP_ADDI, 0,  0,  25, 'h0001, 25, 'h00000001);
    add_row("r0_read_wt",  1, OP_OR,   0,  2,  26, 'h0000, 26, 'h00000005);
    add_row("bub_prod",    1, OP_ADDI, 0,  0,  27, 'h0077, 27, 'h00000077);
    add_row("bubble_r27",  0, OP_ADDI, 0,  0,  27, 'h0999, 0,  'h0);  // Stale if forwarded
    add_row("bubble_r5",   0, OP_ADDI, 0,  0,  5,  'h0888, 0,  'h0);
    add_row("bub_use",     1, OP_ADD,  27, 5,  28, 'h0000, 28, 'h0000016c);
  endtask

  task automatic check_value(input string name,
                             input logic [`CPU_REG_WIDTH-1:0] expected,
                             input logic [`CPU_REG_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("error: %s expected %0h actual %0h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_row(input int k);
    check_value({name_q[k], " wb_valid"}, reg_t'(issue_q[k]), reg_t'(wb_valid));
    if (issue_q[k])
    begin
      check_value({name_q[k], " wb_rd"}, reg_t'(exp_rd_q[k]), reg_t'(wb_rd));
      check_value({name_q[k], " wb_data"}, exp_data_q[k], wb_data);
    end
  endtask

  task automatic drive_row(input int k);
    issue = issue_q[k];
    op    = op_q[k];
    rs    = rs_q[k];
    rt    = rt_q[k];
    rd    = rd_q[k];
    imm   = imm_q[k];
  endtask

  // Run limit follows the table length
  always @(posedge clk)
  begin
    if (!rst_n)
      cycle_cnt <= 0;
    else
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= name_q.size() + LATENCY + MARGIN)
      begin
        $display("timeout: the run did not finish within %0d cycles", cycle_cnt);
        $display("TB FAILED");
        $fatal(1, "run stopped by the cycle limit");
      end
    end
  end

  initial
  begin
    issue = 1'b0;
    op    = OP_ADD;
    rs    = '0;
    rt    = '0;
    rd    = '0;
    imm   = '0;
    build_table();
    wait (rst_n === 1'b1);
    for (int c = 0; c < name_q.size() + LATENCY; c++)
    begin
      @(negedge clk);
      if (c >= LATENCY)
        check_row(c - LATENCY);        // Row sampled three edges back
      if (c < name_q.size())
        drive_row(c);
      else
        issue = 1'b0;                  // Drain with bubbles
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: int_pipe.f
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/cpu_ops_pkg.sv
rtl/decode_stage.sv
rtl/operand_fwd.sv
rtl/exec_pipe.sv
rtl/int_pipe_top.sv
tb/tb_clkgen.sv
tb/tb_int_pipe.sv
